/* lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data RAM sizing and timing

// number of 32-bit words in the data RAM
// addresses wrap modulo this depth
`define LSU_RAM_WORDS 256

// cycles from the first cycle a request is seen to its done pulse
// must be 1 or more
`define LSU_RAM_WAIT 2

`endif

/* mem_op_pkg.sv */
`default_nettype none

package mem_op_pkg;

    // byte lane select bits of an address
    localparam int LANE_W = 2;

    // one write-mask bit per byte lane
    localparam int STRB_W = 1 << LANE_W;

    localparam int SIZE_W = 2;

    typedef enum logic [SIZE_W-1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // memory operation carried with each instruction, 5 bits
    typedef struct packed {
        logic      is_mem;
        logic      is_store;
        logic      is_unsigned;
        mem_size_e size;
    } mem_op_t;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // architectural register index
    localparam int REG_IDX_W = 5;

    localparam int NUM_REGS = 1 << REG_IDX_W;

    // result width carried on the forwarding path
    localparam int VALUE_W = 32;

    // bypass record, from the top: value, register index, write enable
    localparam int BYPASS_W = VALUE_W + REG_IDX_W + 1;

endpackage

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic                              in_valid,
    output      logic                              in_ready,
    input  wire mem_op_pkg::mem_op_t               in_op,
    input  wire logic [31:0]                       in_addr,
    input  wire logic [31:0]                       in_sdata,
    input  wire logic [pipe_pkg::REG_IDX_W-1:0]    in_wreg_idx,
    input  wire logic                              in_wreg_en,
    input  wire logic [31:0]                       in_pc,
    output      logic                              ram_en,
    output      logic                              ram_we,
    output      logic [31:0]                       ram_addr,
    output      logic [mem_op_pkg::STRB_W-1:0]     ram_wmask,
    output      logic [31:0]                       ram_wdata,
    input  wire logic [31:0]                       ram_rdata,
    input  wire logic                              ram_rvalid,
    input  wire logic                              ram_wdone,
    output      logic [pipe_pkg::BYPASS_W-1:0]     bypass,
    output      logic                              out_valid,
    output      logic [31:0]                       out_pc,
    output      logic [pipe_pkg::REG_IDX_W-1:0]    out_wreg_idx,
    output      logic                              out_wreg_en,
    output      logic [31:0]                       out_value
);

    logic [mem_op_pkg::LANE_W-1:0] lane;
    logic [7:0]                    byte_lane;
    logic [15:0]                   half_lane;
    logic [31:0]                   load_val;
    logic [31:0]                   mem_result;
    logic                          is_load;
    logic                          wreg_en_eff;
    logic                          ram_done;
    logic                          fire;

    assign lane    = in_addr[mem_op_pkg::LANE_W-1:0];
    assign is_load = in_op.is_mem & ~in_op.is_store;

    // stores never write the register file
    assign wreg_en_eff = in_wreg_en & ~(in_op.is_mem & in_op.is_store);

    // store alignment into the addressed lane
    always_comb begin
        case (in_op.size)
            mem_op_pkg::SIZE_BYTE: begin
                ram_wdata = {24'h0, in_sdata[7:0]} << {lane, 3'b000};
                ram_wmask = mem_op_pkg::STRB_W'(1) << lane;
            end
            mem_op_pkg::SIZE_HALF: begin
                ram_wdata = lane[1] ? {in_sdata[15:0], 16'h0} : {16'h0, in_sdata[15:0]};
                ram_wmask = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                ram_wdata = in_sdata;
                ram_wmask = '1;
            end
        endcase
    end

    // load lane select and extension
    always_comb begin
        byte_lane = ram_rdata[{lane, 3'b000} +: 8];
        half_lane = lane[1] ? ram_rdata[31:16] : ram_rdata[15:0];
        case (in_op.size)
            mem_op_pkg::SIZE_BYTE:
                load_val = in_op.is_unsigned ? {24'h0, byte_lane}
                                             : {{24{byte_lane[7]}}, byte_lane};
            mem_op_pkg::SIZE_HALF:
                load_val = in_op.is_unsigned ? {16'h0, half_lane}
                                             : {{16{half_lane[15]}}, half_lane};
            default:
                load_val = ram_rdata;
        endcase
    end

    // non-memory ops and stores carry the address value
    assign mem_result = is_load ? load_val : in_addr;

    assign ram_en   = in_valid & in_op.is_mem;
    assign ram_we   = in_op.is_store;
    assign ram_addr = in_addr;

    // hold the upstream until the RAM reports completion
    assign ram_done = ram_we ? ram_wdone : ram_rvalid;
    assign in_ready = ~ram_en | ram_done;
    assign fire     = in_valid & in_ready;

    assign bypass = {mem_result, in_wreg_idx, wreg_en_eff & in_valid};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_pc       <= in_pc;
            out_wreg_idx <= in_wreg_idx;
            out_wreg_en  <= wreg_en_eff;
            out_value    <= mem_result;
        end
    end

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module data_ram (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic                          ram_en,
    input  wire logic                          ram_we,
    input  wire logic [31:0]                   ram_addr,
    input  wire logic [mem_op_pkg::STRB_W-1:0] ram_wmask,
    input  wire logic [31:0]                   ram_wdata,
    output      logic [31:0]                   ram_rdata,
    output      logic                          ram_rvalid,
    output      logic                          ram_wdone
);

    localparam int RAM_WORDS = `LSU_RAM_WORDS;
    localparam int RAM_WAIT  = `LSU_RAM_WAIT;
    localparam int AW        = $clog2(RAM_WORDS);
    localparam int CNT_W     = (RAM_WAIT > 1) ? $clog2(RAM_WAIT) : 1;

    logic [31:0]                   mem [RAM_WORDS];
    logic [29:0]                   word_num;
    logic [AW-1:0]                 req_idx;
    logic [AW-1:0]                 idx_q;
    logic                          we_q;
    logic [mem_op_pkg::STRB_W-1:0] mask_q;
    logic [31:0]                   wdata_q;
    logic                          busy;
    logic [CNT_W-1:0]              cnt;
    logic                          done;
    logic                          start;
    logic                          finish;

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // word address wraps at the RAM depth
    assign word_num = ram_addr[31:2] % 30'(RAM_WORDS);
    assign req_idx  = word_num[AW-1:0];

    // no new request in the cycle of a done pulse
    assign start  = ram_en & ~busy & ~done;
    assign finish = (start && RAM_WAIT == 1) || (busy && cnt == CNT_W'(RAM_WAIT - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= finish;
            if (finish) begin
                busy <= 1'b0;
            end else if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(1);
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign ram_rvalid = done & ~we_q;
    assign ram_wdone  = done & we_q;

    // request latched when accepted
    always_ff @(posedge clk) begin
        if (start) begin
            idx_q   <= req_idx;
            we_q    <= ram_we;
            mask_q  <= ram_wmask;
            wdata_q <= ram_wdata;
        end
    end

    // access takes place on the edge that raises done
    always @(posedge clk) begin
        if (finish) begin
            if (RAM_WAIT == 1 ? ram_we : we_q) begin
                for (int b = 0; b < mem_op_pkg::STRB_W; b++) begin
                    if (RAM_WAIT == 1 ? ram_wmask[b] : mask_q[b]) begin
                        mem[RAM_WAIT == 1 ? req_idx : idx_q][8*b +: 8] <=
                            RAM_WAIT == 1 ? ram_wdata[8*b +: 8] : wdata_q[8*b +: 8];
                    end
                end
            end
            ram_rdata <= mem[RAM_WAIT == 1 ? req_idx : idx_q];
        end
    end

endmodule

`default_nettype wire

/* wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    input  wire logic                           out_valid,
    input  wire logic [31:0]                    out_pc,
    input  wire logic [pipe_pkg::REG_IDX_W-1:0] out_wreg_idx,
    input  wire logic                           out_wreg_en,
    input  wire logic [31:0]                    out_value,
    output      logic                           ret_valid,
    output      logic [31:0]                    ret_pc,
    output      logic [pipe_pkg::REG_IDX_W-1:0] ret_wreg_idx,
    output      logic                           ret_wreg_en,
    output      logic [31:0]                    ret_value,
    input  wire logic [pipe_pkg::REG_IDX_W-1:0] rf_ridx,
    output      logic [31:0]                    rf_rdata
);

    logic [31:0] rf [pipe_pkg::NUM_REGS];
    logic        rf_we;

    // register 0 is never written
    assign rf_we = out_valid & out_wreg_en & (out_wreg_idx != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ret_valid <= 1'b0;
            for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else begin
            ret_valid <= out_valid;
            if (rf_we) begin
                rf[out_wreg_idx] <= out_value;
            end
        end
    end

    // retire report
    always_ff @(posedge clk) begin
        if (out_valid) begin
            ret_pc       <= out_pc;
            ret_wreg_idx <= out_wreg_idx;
            ret_wreg_en  <= out_wreg_en;
            ret_value    <= out_value;
        end
    end

    assign rf_rdata = (rf_ridx == '0) ? 32'h0 : rf[rf_ridx];

endmodule

`default_nettype wire

/* lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    input  wire logic                           in_valid,
    output      logic                           in_ready,
    input  wire mem_op_pkg::mem_op_t            in_op,
    input  wire logic [31:0]                    in_addr,
    input  wire logic [31:0]                    in_sdata,
    input  wire logic [pipe_pkg::REG_IDX_W-1:0] in_wreg_idx,
    input  wire logic                           in_wreg_en,
    input  wire logic [31:0]                    in_pc,
    output      logic [pipe_pkg::BYPASS_W-1:0]  bypass,
    output      logic                           ret_valid,
    output      logic [31:0]                    ret_pc,
    output      logic [pipe_pkg::REG_IDX_W-1:0] ret_wreg_idx,
    output      logic                           ret_wreg_en,
    output      logic [31:0]                    ret_value,
    input  wire logic [pipe_pkg::REG_IDX_W-1:0] rf_ridx,
    output      logic [31:0]                    rf_rdata
);

    // memory stage to RAM
    logic                          ram_en;
    logic                          ram_we;
    logic [31:0]                   ram_addr;
    logic [mem_op_pkg::STRB_W-1:0] ram_wmask;
    logic [31:0]                   ram_wdata;
    logic [31:0]                   ram_rdata;
    logic                          ram_rvalid;
    logic                          ram_wdone;

    // memory stage to write-back
    logic                           out_valid;
    logic [31:0]                    out_pc;
    logic [pipe_pkg::REG_IDX_W-1:0] out_wreg_idx;
    logic                           out_wreg_en;
    logic [31:0]                    out_value;

    mem_stage u_mem_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_op        (in_op),
        .in_addr      (in_addr),
        .in_sdata     (in_sdata),
        .in_wreg_idx  (in_wreg_idx),
        .in_wreg_en   (in_wreg_en),
        .in_pc        (in_pc),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wmask    (ram_wmask),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata),
        .ram_rvalid   (ram_rvalid),
        .ram_wdone    (ram_wdone),
        .bypass       (bypass),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .out_wreg_idx (out_wreg_idx),
        .out_wreg_en  (out_wreg_en),
        .out_value    (out_value)
    );

    data_ram u_data_ram (
        .clk        (clk),
        .arst_n     (arst_n),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wmask  (ram_wmask),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .ram_rvalid (ram_rvalid),
        .ram_wdone  (ram_wdone)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .out_valid    (out_valid),
        .out_pc       (out_pc),
        .out_wreg_idx (out_wreg_idx),
        .out_wreg_en  (out_wreg_en),
        .out_value    (out_value),
        .ret_valid    (ret_valid),
        .ret_pc       (ret_pc),
        .ret_wreg_idx (ret_wreg_idx),
        .ret_wreg_en  (ret_wreg_en),
        .ret_value    (ret_value),
        .rf_ridx      (rf_ridx),
        .rf_rdata     (rf_rdata)
    );

endmodule

`default_nettype wire

/* lsu_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_checker #(
    parameter int NAME_W = 128
) (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    input  wire logic                           in_valid,
    input  wire logic                           in_ready,
    input  wire logic [pipe_pkg::BYPASS_W-1:0]  bypass,
    input  wire logic                           ret_valid,
    input  wire logic [31:0]                    ret_pc,
    input  wire logic [pipe_pkg::REG_IDX_W-1:0] ret_wreg_idx,
    input  wire logic                           ret_wreg_en,
    input  wire logic [31:0]                    ret_value,
    input  wire logic [31:0]                    rf_rdata,
    input  wire logic                           exp_push,
    input  wire logic                           rf_check,
    input  wire logic                           run_done,
    input  wire logic [NAME_W-1:0]              exp_name,
    input  wire logic [31:0]                    exp_value,
    input  wire logic [31:0]                    exp_pc,
    input  wire logic [pipe_pkg::REG_IDX_W-1:0] exp_idx,
    input  wire logic                           exp_en,
    output int                                  seen,
    output int                                  value_errors,
    output int                                  other_errors
);

    typedef struct packed {
        logic [NAME_W-1:0]              name;
        logic [31:0]                    value;
        logic [31:0]                    pc;
        logic [pipe_pkg::REG_IDX_W-1:0] idx;
        logic                           en;
    } exp_rec_t;

    exp_rec_t                      exp_q [$];
    exp_rec_t                      rec_q;
    exp_rec_t                      cur;
    logic                          push_q;
    logic                          rf_q;
    logic                          done_q;
    logic                          fire_q;
    logic                          idle_q;
    logic [pipe_pkg::BYPASS_W-1:0] bypass_q;
    logic                          reported  = 1'b0;
    int                            seen_cnt  = 0;
    int                            value_cnt = 0;
    int                            other_cnt = 0;

    assign seen         = seen_cnt;
    assign value_errors = value_cnt;
    assign other_errors = other_cnt;

    task automatic compare_field(input string field, input logic [NAME_W-1:0] name,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %0s %0s expected %0h actual %0h", name, field, expected, actual);
            value_cnt++;
        end
    endtask

    // requests from the testbench, stable at the rising edge
    // the bypass record is taken at the same edge as the transfer
    always @(posedge clk) begin
        push_q   <= exp_push;
        rf_q     <= rf_check;
        done_q   <= run_done;
        fire_q   <= arst_n & in_valid & in_ready;
        idle_q   <= arst_n & ~in_valid;
        bypass_q <= bypass;
        rec_q    <= '{exp_name, exp_value, exp_pc, exp_idx, exp_en};
    end

    // DUT outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (arst_n) begin
            if (ret_valid) begin
                seen_cnt++;
                if (exp_q.size() == 0) begin
                    $display("a retire with value %0h came with no test waiting for it",
                             ret_value);
                    other_cnt++;
                end else begin
                    cur = exp_q.pop_front();
                    compare_field("ret_value", cur.name, cur.value, ret_value);
                    compare_field("ret_pc", cur.name, cur.pc, ret_pc);
                    compare_field("ret_wreg_idx", cur.name, 32'(cur.idx), 32'(ret_wreg_idx));
                    compare_field("ret_wreg_en", cur.name, 32'(cur.en), 32'(ret_wreg_en));
                end
            end
            if (rf_q) begin
                compare_field("rf_rdata", rec_q.name, rec_q.value, rf_rdata);
            end
            // bypass from the top: value, register index, write enable
            if (fire_q) begin
                compare_field("bypass value", rec_q.name, rec_q.value,
                              bypass_q[pipe_pkg::BYPASS_W-1 -: 32]);
                compare_field("bypass idx", rec_q.name, 32'(rec_q.idx),
                              32'(bypass_q[pipe_pkg::REG_IDX_W:1]));
                compare_field("bypass en", rec_q.name, 32'(rec_q.en), 32'(bypass_q[0]));
            end
            if (idle_q && bypass_q[0] !== 1'b0) begin
                $display("bypass write enable was high with no valid instruction");
                other_cnt++;
            end
            if (push_q) begin
                exp_q.push_back(rec_q);
            end
            // anything still queued here never retired
            if (done_q && !reported) begin
                reported = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("%0d tests were issued but never retired", exp_q.size());
                    other_cnt++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_lsu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module tb_lsu;

    localparam int CLK_PERIOD   = 8;
    localparam int SAMPLE_DLY   = CLK_PERIOD / 4;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_SEED    = 5;
    localparam int NAME_W       = 8 * 16;

    logic                           clk;
    logic                           arst_n;
    logic                           in_valid;
    logic                           in_ready;
    mem_op_pkg::mem_op_t            in_op;
    logic [31:0]                    in_addr;
    logic [31:0]                    in_sdata;
    logic [pipe_pkg::REG_IDX_W-1:0] in_wreg_idx;
    logic                           in_wreg_en;
    logic [31:0]                    in_pc;
    logic [pipe_pkg::BYPASS_W-1:0]  bypass;
    logic                           ret_valid;
    logic [31:0]                    ret_pc;
    logic [pipe_pkg::REG_IDX_W-1:0] ret_wreg_idx;
    logic                           ret_wreg_en;
    logic [31:0]                    ret_value;
    logic [pipe_pkg::REG_IDX_W-1:0] rf_ridx;
    logic [31:0]                    rf_rdata;

    // expectations handed to the checker
    logic                           exp_push;
    logic                           rf_check;
    logic                           run_done;
    logic [NAME_W-1:0]              exp_name;
    logic [31:0]                    exp_value;
    logic [31:0]                    exp_pc;
    logic [pipe_pkg::REG_IDX_W-1:0] exp_idx;
    logic                           exp_en;
    int                             seen;
    int                             value_errors;
    int                             other_errors;

    // test table from the data file
    logic [NAME_W-1:0]              t_name [$];
    mem_op_pkg::mem_op_t            t_op [$];
    bit                             t_rf [$];
    logic [31:0]                    t_addr [$];
    logic [31:0]                    t_sdata [$];
    logic [pipe_pkg::REG_IDX_W-1:0] t_reg [$];
    logic [31:0]                    t_exp [$];

    int cycle_cnt   = 0;
    int cycle_limit = 0;
    int issued      = 0;

    lsu_top i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_op        (in_op),
        .in_addr      (in_addr),
        .in_sdata     (in_sdata),
        .in_wreg_idx  (in_wreg_idx),
        .in_wreg_en   (in_wreg_en),
        .in_pc        (in_pc),
        .bypass       (bypass),
        .ret_valid    (ret_valid),
        .ret_pc       (ret_pc),
        .ret_wreg_idx (ret_wreg_idx),
        .ret_wreg_en  (ret_wreg_en),
        .ret_value    (ret_value),
        .rf_ridx      (rf_ridx),
        .rf_rdata     (rf_rdata)
    );

    lsu_checker #(
        .NAME_W (NAME_W)
    ) u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .bypass       (bypass),
        .ret_valid    (ret_valid),
        .ret_pc       (ret_pc),
        .ret_wreg_idx (ret_wreg_idx),
        .ret_wreg_en  (ret_wreg_en),
        .ret_value    (ret_value),
        .rf_rdata     (rf_rdata),
        .exp_push     (exp_push),
        .rf_check     (rf_check),
        .run_done     (run_done),
        .exp_name     (exp_name),
        .exp_value    (exp_value),
        .exp_pc       (exp_pc),
        .exp_idx      (exp_idx),
        .exp_en       (exp_en),
        .seen         (seen),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // mnemonic to memory op, rf marks a register read check
    function automatic bit decode_op(input logic [63:0] mnem,
                                     output mem_op_pkg::mem_op_t op,
                                     output bit is_rf);
        bit known;
        known = 1'b1;
        is_rf = 1'b0;
        op    = '0;
        case (mnem)
            "sw":    op = '{1'b1, 1'b1, 1'b0, mem_op_pkg::SIZE_WORD};
            "sh":    op = '{1'b1, 1'b1, 1'b0, mem_op_pkg::SIZE_HALF};
            "sb":    op = '{1'b1, 1'b1, 1'b0, mem_op_pkg::SIZE_BYTE};
            "lw":    op = '{1'b1, 1'b0, 1'b0, mem_op_pkg::SIZE_WORD};
            "lh":    op = '{1'b1, 1'b0, 1'b0, mem_op_pkg::SIZE_HALF};
            "lhu":   op = '{1'b1, 1'b0, 1'b1, mem_op_pkg::SIZE_HALF};
            "lb":    op = '{1'b1, 1'b0, 1'b0, mem_op_pkg::SIZE_BYTE};
            "lbu":   op = '{1'b1, 1'b0, 1'b1, mem_op_pkg::SIZE_BYTE};
            "alu":   op = '{1'b0, 1'b0, 1'b0, mem_op_pkg::SIZE_WORD};
            "rf":    is_rf = 1'b1;
            default: known = 1'b0;
        endcase
        return known;
    endfunction

    task automatic load_tests(output bit ok);
        int                  fd;
        int                  n;
        string               line;
        logic [NAME_W-1:0]   name_v;
        logic [63:0]         op_v;
        logic [31:0]         addr_v;
        logic [31:0]         sdata_v;
        int                  reg_v;
        logic [31:0]         exp_v;
        mem_op_pkg::mem_op_t op;
        bit                  is_rf;
        ok = 1'b1;
        fd = $fopen("lsu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open lsu_tests.txt");
            ok = 1'b0;
        end else begin
            while (ok && !$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#") begin
                    continue;
                end
                name_v = '0;
                op_v   = '0;
                n = $sscanf(line, "%s %s %h %h %d %h",
                            name_v, op_v, addr_v, sdata_v, reg_v, exp_v);
                if (n <= 0) begin
                    continue;
                end
                if (n != 6 || !decode_op(op_v, op, is_rf)) begin
                    $display("bad line in lsu_tests.txt: %0s", line);
                    ok = 1'b0;
                end else begin
                    t_name.push_back(name_v);
                    t_op.push_back(op);
                    t_rf.push_back(is_rf);
                    t_addr.push_back(addr_v);
                    t_sdata.push_back(sdata_v);
                    t_reg.push_back(reg_v[pipe_pkg::REG_IDX_W-1:0]);
                    t_exp.push_back(exp_v);
                end
            end
            $fclose(fd);
        end
    endtask

    // checker counters move on the falling edge, read them on the rising one
    task automatic wait_retired();
        do begin
            @(posedge clk);
        end while (seen < issued);
    endtask

    task automatic send_test(input int t);
        mem_op_pkg::mem_op_t op;
        op          = t_op[t];
        in_valid    = 1'b1;
        in_op       = op;
        in_addr     = t_addr[t];
        in_sdata    = t_sdata[t];
        in_wreg_idx = t_reg[t];
        in_wreg_en  = 1'b1;
        in_pc       = 32'(4 * t);
        exp_push    = 1'b1;
        exp_name    = t_name[t];
        exp_value   = t_exp[t];
        exp_pc      = 32'(4 * t);
        exp_idx     = t_reg[t];
        // a store retires without a register write
        exp_en      = ~(op.is_mem & op.is_store);
        issued++;
        #SAMPLE_DLY;
        while (!in_ready) begin
            @(negedge clk);
            exp_push = 1'b0;
            #SAMPLE_DLY;
        end
        @(negedge clk);
        exp_push = 1'b0;
        in_valid = 1'b0;
    endtask

    task automatic check_reg(input int t);
        wait_retired();
        @(negedge clk);
        rf_ridx   = t_reg[t];
        rf_check  = 1'b1;
        exp_name  = t_name[t];
        exp_value = t_exp[t];
        @(negedge clk);
        rf_check = 1'b0;
    endtask

    task automatic run_tests();
        int gap;
        cycle_limit = t_name.size() * (`LSU_RAM_WAIT + 6) + 100;

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        for (int t = 0; t < t_name.size(); t++) begin
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            if (t_rf[t]) begin
                check_reg(t);
            end else begin
                send_test(t);
            end
        end

        // drain, then let the checker look for leftovers
        wait_retired();
        @(negedge clk);
        run_done = 1'b1;
        @(posedge clk);
        @(posedge clk);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d value, %0d other", value_errors, other_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        bit loaded;
        void'($urandom(RAND_SEED));
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_op       = '0;
        in_addr     = '0;
        in_sdata    = '0;
        in_wreg_idx = '0;
        in_wreg_en  = 1'b0;
        in_pc       = '0;
        rf_ridx     = '0;
        exp_push    = 1'b0;
        rf_check    = 1'b0;
        run_done    = 1'b0;
        exp_name    = '0;
        exp_value   = '0;
        exp_pc      = '0;
        exp_idx     = '0;
        exp_en      = 1'b0;
        load_tests(loaded);
        if (!loaded) begin
            $display("TEST FAILED");
            $finish;
        end else begin
            run_tests();
        end
    end

endmodule

`default_nettype wire

/* lsu_tests.txt */
# name  op  address(hex)  store_data(hex)  register(dec)  expected(hex)
# op is sw sh sb lw lh lhu lb lbu alu, or rf to read a register and expect its value
sw_a       sw   00000100 12345678 1  00000100
sw_b       sw   00000104 cafef00d 2  00000104
lw_a       lw   00000100 00000000 3  12345678
lw_b       lw   00000104 00000000 4  cafef00d
rf_r3      rf   00000000 00000000 3  12345678
lw_wrap    lw   00000500 00000000 10 12345678
sb_lane0   sb   00000200 000000a1 9  00000200
sb_lane1   sb   00000201 000000b2 9  00000201
sb_lane2   sb   00000202 000000c3 9  00000202
sb_lane3   sb   00000203 ffffffd4 9  00000203
lw_lanes   lw   00000200 00000000 5  d4c3b2a1
sb_mid     sb   00000106 00000055 9  00000106
lw_mid     lw   00000104 00000000 6  ca55f00d
rf_r5      rf   00000000 00000000 5  d4c3b2a1
sw_known   sw   00000300 7f80c001 1  00000300
lb_lane0   lb   00000300 00000000 11 00000001
lbu_lane0  lbu  00000300 00000000 12 00000001
lb_lane1   lb   00000301 00000000 13 ffffffc0
lbu_lane1  lbu  00000301 00000000 14 000000c0
lb_lane2   lb   00000302 00000000 15 ffffff80
lbu_lane2  lbu  00000302 00000000 16 00000080
lb_lane3   lb   00000303 00000000 17 0000007f
lbu_lane3  lbu  00000303 00000000 18 0000007f
lh_lo      lh   00000300 00000000 19 ffffc001
lhu_lo     lhu  00000300 00000000 20 0000c001
lh_hi      lh   00000302 00000000 21 00007f80
lhu_hi     lhu  00000302 00000000 22 00007f80
sh_hi      sh   00000402 1234abcd 1  00000402
sh_lo      sh   00000400 00008765 1  00000400
lw_half    lw   00000400 00000000 23 abcd8765
lh_neg     lh   00000402 00000000 24 ffffabcd
alu_a      alu  deadbeef 00000000 7  deadbeef
alu_b      alu  0000002a 00000000 8  0000002a
alu_r0     alu  11111111 00000000 0  11111111
rf_r6      rf   00000000 00000000 6  ca55f00d
rf_r7      rf   00000000 00000000 7  deadbeef
rf_r13     rf   00000000 00000000 13 ffffffc0
rf_r20     rf   00000000 00000000 20 0000c001
rf_r24     rf   00000000 00000000 24 ffffabcd
rf_r0      rf   00000000 00000000 0  00000000
rf_r1      rf   00000000 00000000 1  00000000

/* sim.f */
+incdir+.
mem_op_pkg.sv
pipe_pkg.sv
mem_stage.sv
data_ram.sv
wb_stage.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_lsu -o Vtb_lsu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
